// File: compile.f
source/armPkg.sv
source/branchPredictor.sv
source/datapath.sv
source/hazardUnit.sv
source/arm.sv
sim/clockGen.sv
sim/armTb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module armTb -Mdir obj_dir \
  -f compile.f > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/VarmTb > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"

// File: sim/armTb.sv
`timescale 1ns/100ps

module armTb import armPkg::*; ();

  localparam int RomWords = 256;
  // Five runs of at most about 100 cycles, each with 10 reset cycles
  localparam int TimeoutCycles = 2000;

  logic       clk;
  logic       reset;
  logic       restart;
  word        instrF;
  word        pcF;
  word        r0;
  word        r1;
  word        prog [RomWords];
  int         progLen;
  word        haltPc;
  logic [7:0] rndImm [20];
  int         seed;
  int         errorCount;
  int         cycleCount;

  clockGen clocks (.restart(restart), .clk(clk), .reset(reset));

  arm uut (.clk(clk), .reset(reset), .InstrF(instrF), .PCF(pcF), .R0(r0), .R1(r1));

  assign instrF = prog[pcF[9:2]];  // Combinational ROM

  function automatic word dpImm(aluOp op, regIdx rd, regIdx rn, logic [7:0] imm);
    return {CondAl, 3'b001, op, (op == OpCmp), rn, rd, 4'h0, imm};
  endfunction

  function automatic word dpReg(aluOp op, regIdx rd, regIdx rn, regIdx rm);
    return {CondAl, 3'b000, op, (op == OpCmp), rn, rd, 8'h00, rm};
  endfunction

  // Offset counted from the slot about to be written
  function automatic word branchTo(logic [3:0] cond, int targetIdx);
    int offset;
    offset = targetIdx - (progLen + 2);
    return {cond, 4'b1010, offset[23:0]};
  endfunction

  // Architectural model, one instruction at a time, no pipeline
  function automatic logic [63:0] armModel();
    word  regs [16];
    word  pc;
    word  ins;
    word  opB;
    word  target;
    logic z;
    logic taken;
    logic halted;
    int   steps;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    pc = '0;
    z = 1'b0;
    halted = 1'b0;
    steps = 0;
    while (!halted && steps < 1000) begin
      ins = prog[pc[9:2]];
      steps++;
      if (ins[27:25] == 3'b101) begin
        target = pc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
        taken = ins[31:28] == CondAl || (ins[31:28] == CondEq && z)
                || (ins[31:28] == CondNe && !z);
        halted = taken && target == pc;
        pc = taken ? target : pc + 32'd4;
      end else begin
        opB = ins[25] ? {24'd0, ins[7:0]} : regs[ins[3:0]];
        if (ins[27:26] == 2'b00) begin
          case (ins[24:21])
            OpAdd:   regs[ins[15:12]] = regs[ins[19:16]] + opB;
            OpSub:   regs[ins[15:12]] = regs[ins[19:16]] - opB;
            OpMov:   regs[ins[15:12]] = opB;
            OpCmp:   z = regs[ins[19:16]] == opB;
            default: ;
          endcase
        end
        pc = pc + 32'd4;
      end
    end
    return {regs[1], regs[0]};
  endfunction

  task automatic checkWord(string name, word expected, word actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkPc(word expected);
    if (pcF !== expected) begin
      $display("MISMATCH PCF expected %h actual %h", expected, pcF);
      errorCount++;
    end
  endtask

  task automatic emit(word ins);
    prog[progLen] = ins;
    progLen++;
  endtask

  // Unused words decode as neither data processing nor branch
  task automatic clearProgram();
    for (int i = 0; i < RomWords; i++) begin
      prog[i] = 32'hEF000000 + i;
    end
    progLen = 0;
  endtask

  task automatic emitHalt();
    haltPc = word'(progLen * 4);
    emit(branchTo(CondAl, progLen));
  endtask

  // Back-to-back dependencies on R0 and R1
  task automatic buildChain();
    clearProgram();
    emit(dpImm(OpMov, 4'd0, 4'd0, rndImm[0]));
    emit(dpReg(OpMov, 4'd1, 4'd0, 4'd0));
    for (int i = 1; i < 20; i++) begin
      case (i % 3)
        0:       emit(dpReg(OpAdd, 4'd1, 4'd1, 4'd0));
        1:       emit(dpImm(OpSub, 4'd0, 4'd0, rndImm[i]));
        default: emit(dpImm(OpAdd, 4'd0, 4'd1, rndImm[i]));
      endcase
    end
    emitHalt();
  endtask

  task automatic buildLoop();
    clearProgram();
    emit(dpImm(OpMov, 4'd0, 4'd0, 8'd10));
    emit(dpImm(OpMov, 4'd1, 4'd0, 8'd0));
    emit(dpImm(OpAdd, 4'd1, 4'd1, 8'd3));  // Loop body at index 2
    emit(dpImm(OpSub, 4'd0, 4'd0, 8'd1));
    emit(dpImm(OpCmp, 4'd0, 4'd0, 8'd0));
    emit(branchTo(CondNe, 2));
    emitHalt();
  endtask

  // Taken BEQ skips two writes to R1
  task automatic buildSkip();
    clearProgram();
    emit(dpImm(OpMov, 4'd1, 4'd0, 8'd5));
    emit(dpImm(OpMov, 4'd0, 4'd0, 8'd3));
    emit(dpImm(OpCmp, 4'd0, 4'd0, 8'd3));
    emit(branchTo(CondEq, 6));
    emit(dpImm(OpMov, 4'd1, 4'd0, 8'd99));
    emit(dpImm(OpAdd, 4'd1, 4'd1, 8'd1));
    emit(dpImm(OpAdd, 4'd0, 4'd0, 8'd4));
    emitHalt();
  endtask

  task automatic restartCore();
    @(posedge clk);
    #1 restart = 1'b1;
    @(posedge clk);
    #1 restart = 1'b0;
  endtask

  task automatic checkSequentialFetch();
    for (int k = 0; k < 5; k++) begin
      @(negedge clk);
      checkPc(word'(4 * k));
    end
  endtask

  task automatic runToHalt();
    int held;
    held = 0;
    while (held < 8) begin
      @(negedge clk);
      held = (pcF == haltPc) ? held + 1 : 0;
    end
  endtask

  task automatic checkResults();
    logic [63:0] expected;
    expected = armModel();
    checkWord("R0", expected[31:0], r0);
    checkWord("R1", expected[63:32], r1);
  endtask

  task automatic finishRun();
    $display("Error count: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  initial begin
    errorCount = 0;
    restart = 1'b0;
    seed = 77;
    for (int i = 0; i < 20; i++) begin
      rndImm[i] = 8'($random(seed));
    end
    buildChain();
    @(negedge reset);
    checkSequentialFetch();
    runToHalt();
    checkResults();
    restartCore();
    buildLoop();
    @(negedge reset);
    runToHalt();
    checkResults();
    restartCore();
    buildSkip();
    @(negedge reset);
    runToHalt();
    checkResults();
    // Reset again partway through the loop
    restartCore();
    buildLoop();
    @(negedge reset);
    repeat (12) @(posedge clk);
    restartCore();
    @(negedge clk);
    checkPc('0);
    @(negedge reset);
    checkSequentialFetch();
    runToHalt();
    checkResults();
    finishRun();
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, PCF never settled on the halt address", cycleCount);
    errorCount++;
    finishRun();
  end

endmodule

// File: sim/clockGen.sv
`timescale 1ns/100ps

module clockGen (
  input  logic restart,
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // Held for 10 cycles at start and again after each restart request
  always begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    @(posedge restart);
  end

endmodule

// File: source/arm.sv
`timescale 1ns/100ps

module arm import armPkg::*; (
  input  logic clk,
  input  logic reset,
  input  word  InstrF,
  output word  PCF,
  output word  R0,
  output word  R1
);

  hazardCtrl ctrl;
  bpIdx      fetchIndex;
  bpIdx      updateIndex;
  logic      updateEn;
  logic      updateTaken;
  logic      predictTakenF;
  logic      matchAW;
  logic      matchBW;
  logic      regWriteW;
  logic      branchE;
  logic      takenE;
  logic      predictTakenE;

  datapath dp (
    .clk(clk),
    .reset(reset),
    .instrF(InstrF),
    .predictTakenF(predictTakenF),
    .ctrl(ctrl),
    .pcF(PCF),
    .fetchIndex(fetchIndex),
    .updateIndex(updateIndex),
    .updateEn(updateEn),
    .updateTaken(updateTaken),
    .matchAW(matchAW),
    .matchBW(matchBW),
    .regWriteW(regWriteW),
    .branchE(branchE),
    .takenE(takenE),
    .predictTakenE(predictTakenE),
    .r0(R0),
    .r1(R1)
  );

  branchPredictor bp (
    .clk(clk),
    .reset(reset),
    .fetchIndex(fetchIndex),
    .updateEn(updateEn),
    .updateTaken(updateTaken),
    .updateIndex(updateIndex),
    .predictTaken(predictTakenF)
  );

  hazardUnit hu (
    .matchAW(matchAW),
    .matchBW(matchBW),
    .regWriteW(regWriteW),
    .branchE(branchE),
    .takenE(takenE),
    .predictTakenE(predictTakenE),
    .ctrl(ctrl)
  );

endmodule

// File: source/armPkg.sv
package armPkg;

  typedef logic [31:0] word;
  typedef logic [3:0]  regIdx;
  typedef logic [3:0]  bpIdx;
  typedef logic [3:0]  aluOp;

  // Data-processing opcodes, instr[24:21]
  localparam aluOp OpAdd = 4'b0100;
  localparam aluOp OpSub = 4'b0010;
  localparam aluOp OpMov = 4'b1101;
  localparam aluOp OpCmp = 4'b1010;

  localparam logic [3:0] CondEq = 4'b0000;
  localparam logic [3:0] CondNe = 4'b0001;
  localparam logic [3:0] CondAl = 4'b1110;

  localparam int NumPredEntries = 16;

  typedef enum logic [1:0] {
    StrongNot,
    WeakNot,
    WeakTaken,
    StrongTaken
  } counterState;

  typedef struct packed {
    word  instr;
    word  pc;
    logic predictTaken;
  } decodeStage;

  typedef struct packed {
    aluOp       op;
    logic [3:0] cond;
    logic       isBranch;
    logic       isDp;
    logic       regWrite;
    logic       setFlags;
    logic       useImm;
    regIdx      rn;
    regIdx      rd;
    word        srcA;
    word        srcB;         // Immediate already merged in decode
    word        branchTarget;
    word        pc;
    logic       predictTaken;
  } executeStage;

  typedef struct packed {
    logic  regWrite;
    regIdx rd;
    word   result;
  } writebackStage;

  typedef struct packed {
    logic forwardA;
    logic forwardB;
    logic flushD;
    logic flushE;
    logic redirect;
  } hazardCtrl;

endpackage

// File: source/branchPredictor.sv
`timescale 1ns/100ps

module branchPredictor import armPkg::*; (
  input  logic clk,
  input  logic reset,
  input  bpIdx fetchIndex,
  input  logic updateEn,
  input  logic updateTaken,
  input  bpIdx updateIndex,
  output logic predictTaken
);

  counterState counters [NumPredEntries];
  counterState fetchState;

  function automatic counterState stepCounter(counterState cur, logic taken);
    case (cur)
      StrongNot: stepCounter = taken ? WeakNot : StrongNot;
      WeakNot:   stepCounter = taken ? WeakTaken : StrongNot;
      WeakTaken: stepCounter = taken ? StrongTaken : WeakNot;
      default:   stepCounter = taken ? StrongTaken : WeakTaken;  // Saturate high
    endcase
  endfunction

  // Read in fetch
  assign fetchState = counters[fetchIndex];
  assign predictTaken = (fetchState == WeakTaken) || (fetchState == StrongTaken);

  // Update from the branch resolved in execute
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumPredEntries; i++) begin
        counters[i] <= WeakNot;
      end
    end else if (updateEn) begin
      counters[updateIndex] <= stepCounter(counters[updateIndex], updateTaken);
    end
  end

  // Entry seen by fetch always holds a known counter state
  counterInRange: assert property (
    @(posedge clk) disable iff (reset)
    fetchState inside {StrongNot, WeakNot, WeakTaken, StrongTaken}
  );

endmodule

// File: source/datapath.sv
`timescale 1ns/100ps

module datapath import armPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  word       instrF,
  input  logic      predictTakenF,
  input  hazardCtrl ctrl,
  output word       pcF,
  output bpIdx      fetchIndex,
  output bpIdx      updateIndex,
  output logic      updateEn,
  output logic      updateTaken,
  output logic      matchAW,
  output logic      matchBW,
  output logic      regWriteW,
  output logic      branchE,
  output logic      takenE,
  output logic      predictTakenE,
  output word       r0,
  output word       r1
);

  decodeStage    fd;
  executeStage   de;
  executeStage   deNext;
  writebackStage ew;
  logic          validD;
  regIdx         rmE;
  word           rf [16];
  logic          zFlag;

  logic  isBranchF;
  logic  predictF;
  word   targetF;
  word   pcNext;
  aluOp  opD;
  regIdx rnD;
  regIdx rmD;
  regIdx rdD;
  logic  isDpD;
  logic  isBranchD;
  word   readA;
  word   readB;
  word   srcAE;
  word   srcBE;
  word   diffE;
  word   resultE;
  logic  condPass;

  // Fetch
  assign isBranchF = instrF[27:25] == 3'b101;
  assign predictF = isBranchF && predictTakenF;
  assign targetF = pcF + 32'd8 + {{6{instrF[23]}}, instrF[23:0], 2'b00};
  assign fetchIndex = pcF[5:2];

  always_comb begin
    if (ctrl.redirect) begin
      pcNext = takenE ? de.branchTarget : de.pc + 32'd4;
    end else if (predictF) begin
      pcNext = targetF;  // Taken in fetch, no bubble
    end else begin
      pcNext = pcF + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= '0;
    end else begin
      pcF <= pcNext;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || ctrl.flushD) begin
      fd <= '0;
      validD <= 1'b0;
    end else begin
      fd <= '{instr: instrF, pc: pcF, predictTaken: predictF};
      validD <= 1'b1;
    end
  end

  // Decode
  assign opD = fd.instr[24:21];
  assign rnD = fd.instr[19:16];
  assign rdD = fd.instr[15:12];
  assign rmD = fd.instr[3:0];
  assign isDpD = validD && fd.instr[27:26] == 2'b00
                 && (opD inside {OpAdd, OpSub, OpMov, OpCmp});
  assign isBranchD = validD && fd.instr[27:25] == 3'b101;

  // R15 reads as pc+8; writeback value passes straight through
  assign readA = (rnD == 4'hf) ? fd.pc + 32'd8 :
                 (ew.regWrite && ew.rd == rnD) ? ew.result : rf[rnD];
  assign readB = fd.instr[25] ? {24'd0, fd.instr[7:0]} :
                 (rmD == 4'hf) ? fd.pc + 32'd8 :
                 (ew.regWrite && ew.rd == rmD) ? ew.result : rf[rmD];

  always_comb begin
    deNext = '0;
    deNext.op = opD;
    deNext.cond = fd.instr[31:28];
    deNext.isBranch = isBranchD;
    deNext.isDp = isDpD;
    deNext.regWrite = isDpD && opD != OpCmp && rdD != 4'hf;
    deNext.setFlags = isDpD && opD == OpCmp;
    deNext.useImm = fd.instr[25];
    deNext.rn = rnD;
    deNext.rd = rdD;
    deNext.srcA = readA;
    deNext.srcB = readB;
    deNext.branchTarget = fd.pc + 32'd8 + {{6{fd.instr[23]}}, fd.instr[23:0], 2'b00};
    deNext.pc = fd.pc;
    deNext.predictTaken = fd.predictTaken;
  end

  always_ff @(posedge clk) begin
    if (reset || ctrl.flushE) begin
      de <= '0;
      rmE <= '0;
    end else begin
      de <= deNext;
      rmE <= rmD;
    end
  end

  // Execute
  assign matchAW = de.isDp && de.rn == ew.rd;
  assign matchBW = de.isDp && !de.useImm && rmE == ew.rd;
  assign srcAE = ctrl.forwardA ? ew.result : de.srcA;
  assign srcBE = ctrl.forwardB ? ew.result : de.srcB;
  assign diffE = srcAE - srcBE;

  always_comb begin
    case (de.op)
      OpAdd:   resultE = srcAE + srcBE;
      OpMov:   resultE = srcBE;
      default: resultE = diffE;  // SUB and CMP
    endcase
  end

  always_comb begin
    case (de.cond)
      CondEq:  condPass = zFlag;
      CondNe:  condPass = !zFlag;
      CondAl:  condPass = 1'b1;
      default: condPass = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      zFlag <= 1'b0;
    end else if (de.setFlags) begin
      zFlag <= diffE == '0;
    end
  end

  assign branchE = de.isBranch;
  assign takenE = de.isBranch && condPass;
  assign predictTakenE = de.predictTaken;
  assign updateEn = de.isBranch;
  assign updateIndex = de.pc[5:2];
  assign updateTaken = takenE;

  always_ff @(posedge clk) begin
    if (reset) begin
      ew <= '0;
    end else begin
      ew <= '{regWrite: de.regWrite, rd: de.rd, result: resultE};
    end
  end

  // Writeback
  always_ff @(posedge clk) begin
    if (ew.regWrite) begin
      rf[ew.rd] <= ew.result;
    end
  end

  assign regWriteW = ew.regWrite;
  assign r0 = rf[0];
  assign r1 = rf[1];

  redirectNeedsBranch: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.redirect |-> branchE
  );

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit import armPkg::*; (
  input  logic      matchAW,
  input  logic      matchBW,
  input  logic      regWriteW,
  input  logic      branchE,
  input  logic      takenE,
  input  logic      predictTakenE,
  output hazardCtrl ctrl
);

  logic mispredict;

  // Outcome disagrees with what fetch assumed
  assign mispredict = branchE && (takenE != predictTakenE);

  always_comb begin
    ctrl = '0;
    ctrl.forwardA = matchAW && regWriteW;
    ctrl.forwardB = matchBW && regWriteW;
    // Both younger instructions are on the wrong path
    ctrl.flushD = mispredict;
    ctrl.flushE = mispredict;
    ctrl.redirect = mispredict;
  end

  always_comb begin
    flushPair: assert (!ctrl.flushE || ctrl.flushD);
  end

endmodule
